// File: Bender.yml
package:
  name: serv_lite

sources:
  - hdl/serv_pkg.sv
  - hdl/serv_state.sv
  - hdl/serv_decode.sv
  - hdl/serv_immdec.sv
  - hdl/serv_alu.sv
  - hdl/serv_rf.sv
  - hdl/serv_bufreg.sv
  - hdl/serv_top.sv
  - target: test
    files:
      - verif/tb_clock.sv
      - verif/serv_tb.sv

// File: hdl/serv_alu.sv
`timescale 1ns/1ns
`default_nettype none

module serv_alu (
   input  wire                         clk,
   input  wire                         i_cnt_en,
   input  wire  [serv_pkg::CNT_W-1:0]  i_cnt,
   input  wire  serv_pkg::ctrl_t       i_ctrl,
   input  wire                         i_rs1,
   input  wire                         i_rs2,
   input  wire                         i_imm,
   output logic                        o_rd
);
   import serv_pkg::*;

   logic op_b;
   logic sub;
   logic b_in;
   logic c_in;
   logic c_out;
   logic sum;
   logic carry;

   assign op_b = i_ctrl.use_imm ? i_imm : i_rs2;
   assign sub  = (i_ctrl.alu_op == ALU_SUB);

   // Two's complement subtract, carry seeded at bit 0
   assign b_in  = op_b ^ sub;
   assign c_in  = (i_cnt == '0) ? sub : carry;
   assign sum   = i_rs1 ^ b_in ^ c_in;
   assign c_out = (i_rs1 & b_in) | (c_in & (i_rs1 ^ b_in));

   always_ff @(posedge clk) begin
      if (i_cnt_en) begin
         carry <= c_out;
      end
   end

   always_comb begin
      case (i_ctrl.alu_op)
         ALU_XOR: o_rd = i_rs1 ^ op_b;
         ALU_OR:  o_rd = i_rs1 | op_b;
         ALU_AND: o_rd = i_rs1 & op_b;
         default: o_rd = sum;
      endcase
   end

endmodule

`default_nettype wire

// File: hdl/serv_bufreg.sv
`timescale 1ns/1ns
`default_nettype none

module serv_bufreg (
   input  wire                        clk,
   input  wire                        i_cnt_en,
   input  wire  serv_pkg::state_e     i_state,
   input  wire  serv_pkg::ctrl_t      i_ctrl,
   input  wire                        i_alu_rd,
   input  wire                        i_rs2,
   input  wire                        i_dbus_cyc,
   input  wire                        i_dbus_ack,
   input  wire  [serv_pkg::XLEN-1:0]  i_dbus_rdt,
   output serv_pkg::dbus_req_t        o_dbus,
   output logic                       o_mem_rd
);
   import serv_pkg::*;

   // Address bits 1:0 drop off the bottom
   logic [XLEN-1:2] adr_q;
   logic [XLEN-1:0] dat_q;
   logic [XLEN-1:0] ldat_q;
   logic            exec_en;
   logic            load_ack;

   assign exec_en  = i_cnt_en && (i_state == ST_EXEC);
   assign load_ack = i_dbus_cyc && i_dbus_ack && !i_ctrl.mem_we;

   always_ff @(posedge clk) begin
      if (exec_en) begin
         adr_q <= {i_alu_rd, adr_q[XLEN-1:3]};
         dat_q <= {i_rs2, dat_q[XLEN-1:1]};
      end
   end

   // Load data is replayed LSB first in write-back
   always_ff @(posedge clk) begin
      if (load_ack) begin
         ldat_q <= i_dbus_rdt;
      end else if (i_cnt_en && (i_state == ST_WBACK)) begin
         ldat_q <= {1'b0, ldat_q[XLEN-1:1]};
      end
   end

   assign o_mem_rd = ldat_q[0];

   always_comb begin
      o_dbus.adr = {adr_q, 2'b00};
      o_dbus.dat = dat_q;
      o_dbus.we  = i_ctrl.mem_we;
      o_dbus.cyc = i_dbus_cyc;
   end

   // Writes only come from a store in the memory phase
   assert property (@(posedge clk)
      (o_dbus.cyc && o_dbus.we) |-> (i_ctrl.mem_op && i_state == ST_MEM));

   // A store goes straight back to fetch
   assert property (@(posedge clk)
      (o_dbus.cyc && o_dbus.we && i_dbus_ack) |=> (i_state == ST_FETCH));

endmodule

`default_nettype wire

// File: hdl/serv_decode.sv
`timescale 1ns/1ns
`default_nettype none

module serv_decode (
   input  wire                        clk,
   input  wire                        i_en,
   input  wire  [serv_pkg::XLEN-1:0]  i_insn,
   output serv_pkg::ctrl_t            o_ctrl
);
   import serv_pkg::*;

   opcode_e opcode;
   logic    opc_valid;
   alu_op_e alu_op;
   ctrl_t   ctrl_d;

   always_comb begin
      opc_valid = 1'b1;
      opcode    = OPC_OP_IMM;
      case (i_insn[6:2])
         5'b01101: opcode = OPC_LUI;
         5'b00100: opcode = OPC_OP_IMM;
         5'b01100: opcode = OPC_OP;
         5'b00000: opcode = OPC_LOAD;
         5'b01000: opcode = OPC_STORE;
         default:  opc_valid = 1'b0;
      endcase
   end

   // Bit 30 only means SUB for register-register ops
   always_comb begin
      case (i_insn[14:12])
         3'b100:  alu_op = ALU_XOR;
         3'b110:  alu_op = ALU_OR;
         3'b111:  alu_op = ALU_AND;
         default: alu_op = (opcode == OPC_OP && i_insn[30]) ? ALU_SUB : ALU_ADD;
      endcase
   end

   always_comb begin
      ctrl_d         = '0;
      ctrl_d.alu_op  = alu_op;
      ctrl_d.use_rs1 = 1'b1;
      case (opcode)
         OPC_LUI: begin
            ctrl_d.alu_op  = ALU_ADD;
            ctrl_d.use_imm = 1'b1;
            ctrl_d.use_rs1 = 1'b0;
            ctrl_d.rd_wen  = 1'b1;
            ctrl_d.imm_u   = 1'b1;
         end
         OPC_OP_IMM: begin
            ctrl_d.use_imm = 1'b1;
            ctrl_d.rd_wen  = 1'b1;
         end
         OPC_OP: begin
            ctrl_d.rd_wen = 1'b1;
         end
         OPC_LOAD: begin
            ctrl_d.alu_op  = ALU_ADD;
            ctrl_d.use_imm = 1'b1;
            ctrl_d.rd_wen  = 1'b1;
            ctrl_d.mem_op  = 1'b1;
         end
         default: begin
            ctrl_d.alu_op  = ALU_ADD;
            ctrl_d.use_imm = 1'b1;
            ctrl_d.mem_op  = 1'b1;
            ctrl_d.mem_we  = 1'b1;
            ctrl_d.imm_s   = 1'b1;
         end
      endcase
      // Unknown opcodes run as a NOP
      if (!opc_valid) begin
         ctrl_d.rd_wen = 1'b0;
         ctrl_d.mem_op = 1'b0;
         ctrl_d.mem_we = 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (i_en) begin
         o_ctrl <= ctrl_d;
      end
   end

endmodule

`default_nettype wire

// File: hdl/serv_immdec.sv
`timescale 1ns/1ns
`default_nettype none

module serv_immdec (
   input  wire                        clk,
   input  wire                        i_en,
   input  wire  [serv_pkg::XLEN-1:0]  i_insn,
   input  wire  serv_pkg::ctrl_t      i_ctrl,
   input  wire                        i_cnt_en,
   output serv_pkg::reg_addr_t        o_regs,
   output logic                       o_imm
);
   import serv_pkg::*;

   logic [XLEN-1:0] imm_sr;
   // Ones while the count is below 12
   logic [11:0]     low_mask;

   always_ff @(posedge clk) begin
      if (i_en) begin
         o_regs.rd  <= i_insn[11:7];
         o_regs.rs1 <= i_insn[19:15];
         o_regs.rs2 <= i_insn[24:20];
         imm_sr     <= i_insn;
         low_mask   <= '1;
      end else if (i_cnt_en) begin
         // Sign bit refills from the top
         imm_sr   <= {imm_sr[XLEN-1], imm_sr[XLEN-1:1]};
         low_mask <= {1'b0, low_mask[11:1]};
      end
   end

   // I-type taps bit 20, S-type takes bits 11:7 for its first five bits
   always_comb begin
      if (i_ctrl.imm_u) begin
         o_imm = !low_mask[0] && imm_sr[0];
      end else if (i_ctrl.imm_s && low_mask[7]) begin
         o_imm = imm_sr[7];
      end else begin
         o_imm = imm_sr[20];
      end
   end

endmodule

`default_nettype wire

// File: hdl/serv_pkg.sv
`default_nettype none

package serv_pkg;

   localparam int XLEN   = 32;
   localparam int REG_AW = 5;
   localparam int CNT_W  = 5;

   localparam logic [XLEN-1:0] RESET_PC = '0;

   // Major opcodes of the supported subset
   typedef enum logic [2:0] {
      OPC_LUI,
      OPC_OP_IMM,
      OPC_OP,
      OPC_LOAD,
      OPC_STORE
   } opcode_e;

   typedef enum logic [2:0] {
      ALU_ADD,
      ALU_SUB,
      ALU_XOR,
      ALU_OR,
      ALU_AND
   } alu_op_e;

   // Core phases of one instruction
   typedef enum logic [1:0] {
      ST_FETCH,
      ST_EXEC,
      ST_MEM,
      ST_WBACK
   } state_e;

   typedef struct packed {
      alu_op_e alu_op;
      logic    use_imm;
      logic    use_rs1;
      logic    rd_wen;
      logic    mem_op;
      logic    mem_we;
      logic    imm_u;
      logic    imm_s;
   } ctrl_t;

   typedef struct packed {
      logic [XLEN-1:0] adr;
      logic            cyc;
   } ibus_req_t;

   typedef struct packed {
      logic [XLEN-1:0] adr;
      logic [XLEN-1:0] dat;
      logic            we;
      logic            cyc;
   } dbus_req_t;

   typedef struct packed {
      logic [REG_AW-1:0] rd;
      logic [REG_AW-1:0] rs1;
      logic [REG_AW-1:0] rs2;
   } reg_addr_t;

endpackage

`default_nettype wire

// File: hdl/serv_rf.sv
`timescale 1ns/1ns
`default_nettype none

module serv_rf (
   input  wire                         clk,
   input  wire                         i_cnt_en,
   input  wire  [serv_pkg::CNT_W-1:0]  i_cnt,
   input  wire                         i_cnt_done,
   input  wire  serv_pkg::state_e      i_state,
   input  wire  serv_pkg::ctrl_t       i_ctrl,
   input  wire  serv_pkg::reg_addr_t   i_regs,
   input  wire                         i_alu_rd,
   input  wire                         i_mem_rd,
   output logic                        o_rs1,
   output logic                        o_rs2
);
   import serv_pkg::*;

   logic [XLEN-1:0] regs [2**REG_AW];
   logic [XLEN-1:0] rs1_word;
   logic [XLEN-1:0] rs2_word;
   // Bits 30:0 of the result, bit 31 arrives in the commit cycle
   logic [XLEN-2:0] wbuf;
   logic            rd_bit;
   logic            to_wback;
   logic            commit;

   // x0 reads as zero
   assign rs1_word = (i_regs.rs1 == '0) ? '0 : regs[i_regs.rs1];
   assign rs2_word = (i_regs.rs2 == '0) ? '0 : regs[i_regs.rs2];

   assign o_rs1 = i_ctrl.use_rs1 && rs1_word[i_cnt];
   assign o_rs2 = rs2_word[i_cnt];

   assign rd_bit = (i_state == ST_WBACK) ? i_mem_rd : i_alu_rd;

   // Loads commit only after write-back
   assign to_wback = (i_state == ST_EXEC) && i_ctrl.mem_op && !i_ctrl.mem_we;
   assign commit   = i_cnt_done && i_ctrl.rd_wen && !to_wback && (i_regs.rd != '0);

   always_ff @(posedge clk) begin
      if (i_cnt_en) begin
         wbuf <= {rd_bit, wbuf[XLEN-2:1]};
      end
   end

   always_ff @(posedge clk) begin
      if (commit) begin
         regs[i_regs.rd] <= {rd_bit, wbuf};
      end
   end

endmodule

`default_nettype wire

// File: hdl/serv_state.sv
`timescale 1ns/1ns
`default_nettype none

module serv_state (
   input  wire                          clk,
   input  wire                          i_reset,
   input  wire                          i_ibus_ack,
   input  wire                          i_dbus_ack,
   input  wire  serv_pkg::ctrl_t        i_ctrl,
   output serv_pkg::ibus_req_t          o_ibus,
   output logic                         o_dbus_cyc,
   output logic                         o_cnt_en,
   output logic [serv_pkg::CNT_W-1:0]   o_cnt,
   output logic                         o_cnt_done,
   output serv_pkg::state_e             o_state
);
   import serv_pkg::*;

   logic [XLEN-1:0] pc;
   logic            ibus_cyc;

   assign o_cnt_en   = (o_state == ST_EXEC) || (o_state == ST_WBACK);
   assign o_cnt_done = o_cnt_en && (o_cnt == '1);

   always_comb begin
      o_ibus.adr = pc;
      o_ibus.cyc = ibus_cyc;
   end

   always_ff @(posedge clk) begin
      if (i_reset) begin
         o_state    <= ST_FETCH;
         o_cnt      <= '0;
         pc         <= RESET_PC;
         ibus_cyc   <= 1'b0;
         o_dbus_cyc <= 1'b0;
      end else begin
         if (o_cnt_en) begin
            o_cnt <= o_cnt + CNT_W'(1);
         end
         case (o_state)
            ST_FETCH: begin
               // Hold the request until the memory answers
               ibus_cyc <= !(ibus_cyc && i_ibus_ack);
               if (ibus_cyc && i_ibus_ack) begin
                  o_state <= ST_EXEC;
               end
            end
            ST_EXEC: begin
               if (o_cnt_done) begin
                  pc <= pc + XLEN'(4);
                  if (i_ctrl.mem_op) begin
                     o_state    <= ST_MEM;
                     o_dbus_cyc <= 1'b1;
                  end else begin
                     o_state  <= ST_FETCH;
                     ibus_cyc <= 1'b1;
                  end
               end
            end
            ST_MEM: begin
               if (i_dbus_ack) begin
                  o_dbus_cyc <= 1'b0;
                  if (i_ctrl.mem_we) begin
                     o_state  <= ST_FETCH;
                     ibus_cyc <= 1'b1;
                  end else begin
                     o_state <= ST_WBACK;
                  end
               end
            end
            default: begin
               if (o_cnt_done) begin
                  o_state  <= ST_FETCH;
                  ibus_cyc <= 1'b1;
               end
            end
         endcase
      end
   end

   // Only one bus is ever active
   assert property (@(posedge clk) disable iff (i_reset) !(ibus_cyc && o_dbus_cyc));

endmodule

`default_nettype wire

// File: hdl/serv_top.sv
`timescale 1ns/1ns
`default_nettype none

module serv_top (
   input  wire                        clk,
   input  wire                        i_reset,
   output serv_pkg::ibus_req_t        o_ibus,
   input  wire  [serv_pkg::XLEN-1:0]  i_ibus_rdt,
   input  wire                        i_ibus_ack,
   output serv_pkg::dbus_req_t        o_dbus,
   input  wire  [serv_pkg::XLEN-1:0]  i_dbus_rdt,
   input  wire                        i_dbus_ack
);
   import serv_pkg::*;

   ctrl_t            ctrl;
   reg_addr_t        regs;
   state_e           phase;
   logic             cnt_en;
   logic [CNT_W-1:0] cnt;
   logic             cnt_done;
   logic             dbus_cyc;
   logic             imm;
   logic             rs1;
   logic             rs2;
   logic             alu_rd;
   logic             mem_rd;

   serv_state state (
      .clk        (clk),
      .i_reset    (i_reset),
      .i_ibus_ack (i_ibus_ack),
      .i_dbus_ack (i_dbus_ack),
      .i_ctrl     (ctrl),
      .o_ibus     (o_ibus),
      .o_dbus_cyc (dbus_cyc),
      .o_cnt_en   (cnt_en),
      .o_cnt      (cnt),
      .o_cnt_done (cnt_done),
      .o_state    (phase)
   );

   serv_decode decode (
      .clk    (clk),
      .i_en   (i_ibus_ack),
      .i_insn (i_ibus_rdt),
      .o_ctrl (ctrl)
   );

   serv_immdec immdec (
      .clk      (clk),
      .i_en     (i_ibus_ack),
      .i_insn   (i_ibus_rdt),
      .i_ctrl   (ctrl),
      .i_cnt_en (cnt_en),
      .o_regs   (regs),
      .o_imm    (imm)
   );

   serv_alu alu (
      .clk      (clk),
      .i_cnt_en (cnt_en),
      .i_cnt    (cnt),
      .i_ctrl   (ctrl),
      .i_rs1    (rs1),
      .i_rs2    (rs2),
      .i_imm    (imm),
      .o_rd     (alu_rd)
   );

   serv_rf rf (
      .clk        (clk),
      .i_cnt_en   (cnt_en),
      .i_cnt      (cnt),
      .i_cnt_done (cnt_done),
      .i_state    (phase),
      .i_ctrl     (ctrl),
      .i_regs     (regs),
      .i_alu_rd   (alu_rd),
      .i_mem_rd   (mem_rd),
      .o_rs1      (rs1),
      .o_rs2      (rs2)
   );

   serv_bufreg bufreg (
      .clk        (clk),
      .i_cnt_en   (cnt_en),
      .i_state    (phase),
      .i_ctrl     (ctrl),
      .i_alu_rd   (alu_rd),
      .i_rs2      (rs2),
      .i_dbus_cyc (dbus_cyc),
      .i_dbus_ack (i_dbus_ack),
      .i_dbus_rdt (i_dbus_rdt),
      .o_dbus     (o_dbus),
      .o_mem_rd   (mem_rd)
   );

endmodule

`default_nettype wire

// File: src.f
hdl/serv_pkg.sv
hdl/serv_state.sv
hdl/serv_decode.sv
hdl/serv_immdec.sv
hdl/serv_alu.sv
hdl/serv_rf.sv
hdl/serv_bufreg.sv
hdl/serv_top.sv
verif/tb_clock.sv
verif/serv_tb.sv

// File: verif/serv_tb.sv
`timescale 1ns/1ns
`default_nettype none

module serv_tb;
   import serv_pkg::*;

   localparam int TIMEOUT = 6000;
   localparam logic [31:0] NOP = 32'h0000_0013;

   logic            clk;
   logic            gen_reset;
   logic            hold_reset;
   logic            dut_reset;
   logic            reset_q;
   ibus_req_t       ibus;
   dbus_req_t       dbus;
   logic [XLEN-1:0] ibus_rdt;
   logic            ibus_ack;
   logic [XLEN-1:0] dbus_rdt;
   logic            dbus_ack;

   logic [31:0] prog [256];
   logic [31:0] dmem [256];
   int          prog_len;
   int          iwait;
   int          dwait;
   int          err_count;
   integer      seed;

   logic [31:0] fetch_q [$];
   logic [31:0] dadr_q [$];
   logic [31:0] ddat_q [$];
   logic        dwe_q [$];

   assign dut_reset = gen_reset | hold_reset;

   tb_clock clock_gen (
      .clk     (clk),
      .o_reset (gen_reset)
   );

   serv_top UUT (
      .clk        (clk),
      .i_reset    (dut_reset),
      .o_ibus     (ibus),
      .i_ibus_rdt (ibus_rdt),
      .i_ibus_ack (ibus_ack),
      .o_dbus     (dbus),
      .i_dbus_rdt (dbus_rdt),
      .i_dbus_ack (dbus_ack)
   );

   // Instruction memory, random wait before each ack
   always begin
      @(posedge clk);
      #1;
      ibus_ack = 1'b0;
      if (dut_reset) begin
         iwait = -1;
      end else if (ibus.cyc) begin
         if (iwait < 0) iwait = $random(seed) & 3;
         if (iwait == 0) begin
            ibus_ack = 1'b1;
            ibus_rdt = prog[ibus.adr[9:2]];
            fetch_q.push_back(ibus.adr);
            iwait = -1;
         end else begin
            iwait--;
         end
      end
   end

   // Data memory
   always begin
      @(posedge clk);
      #1;
      dbus_ack = 1'b0;
      if (dut_reset) begin
         dwait = -1;
      end else if (dbus.cyc) begin
         if (dwait < 0) dwait = $random(seed) & 3;
         if (dwait == 0) begin
            dbus_ack = 1'b1;
            dbus_rdt = dmem[dbus.adr[9:2]];
            if (dbus.we) dmem[dbus.adr[9:2]] = dbus.dat;
            dadr_q.push_back(dbus.adr);
            ddat_q.push_back(dbus.dat);
            dwe_q.push_back(dbus.we);
            dwait = -1;
         end else begin
            dwait--;
         end
      end
   end

   always @(posedge clk) reset_q <= dut_reset;

   // Both buses idle while in reset
   always @(negedge clk) begin
      if (reset_q) begin
         assert (ibus.cyc === 1'b0 && dbus.cyc === 1'b0) else begin
            $display("Error: reset_idle expected cyc 00 actual %b%b", ibus.cyc, dbus.cyc);
            err_count++;
         end
      end
   end

   function automatic logic [31:0] sext12(input logic [11:0] v);
      return {{20{v[11]}}, v};
   endfunction

   function automatic logic [31:0] enc_i(input logic [6:0] op, input logic [4:0] rd,
                                         input logic [2:0] f3, input logic [4:0] rs1,
                                         input logic [11:0] imm);
      return {imm, rs1, f3, rd, op};
   endfunction

   function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rd,
                                         input logic [2:0] f3, input logic [4:0] rs1,
                                         input logic [4:0] rs2);
      return {f7, rs2, rs1, f3, rd, 7'b0110011};
   endfunction

   function automatic logic [31:0] enc_sw(input logic [4:0] rs2, input logic [4:0] rs1,
                                          input logic [11:0] imm);
      return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
   endfunction

   function automatic logic [31:0] enc_lui(input logic [4:0] rd, input logic [19:0] imm);
      return {imm, rd, 7'b0110111};
   endfunction

   function automatic logic [31:0] enc_addi(input logic [4:0] rd, input logic [4:0] rs1,
                                            input logic [11:0] imm);
      return enc_i(7'b0010011, rd, 3'b000, rs1, imm);
   endfunction

   task automatic emit(input logic [31:0] insn);
      prog[prog_len] = insn;
      prog_len++;
   endtask

   task automatic check_word(input string name, input logic [31:0] exp,
                             input logic [31:0] act);
      assert (exp === act) else begin
         $display("Error: %s expected %h actual %h", name, exp, act);
         err_count++;
      end
   endtask

   task automatic abort_run(input string what);
      $display("%s", what);
      $display("test failed");
      $finish;
   endtask

   // Hold the core in reset while a new program goes in
   task automatic restart_core;
      @(posedge clk);
      #1 hold_reset = 1'b1;
      repeat (8) @(posedge clk);
      fetch_q.delete();
      dadr_q.delete();
      ddat_q.delete();
      dwe_q.delete();
   endtask

   task automatic release_core;
      @(posedge clk);
      #1 hold_reset = 1'b0;
   endtask

   task automatic clear_prog;
      for (int i = 0; i < 256; i++) prog[i] = NOP;
      prog_len = 0;
   endtask

   task automatic wait_dbus(input int n, input string name);
      int cycles;
      cycles = 0;
      while (dadr_q.size() < n && cycles < TIMEOUT) begin
         @(posedge clk);
         cycles++;
      end
      if (dadr_q.size() < n) abort_run({name, ": timed out waiting for data bus accesses"});
   endtask

   task automatic wait_fetch(input int n, input string name);
      int cycles;
      cycles = 0;
      while (fetch_q.size() < n && cycles < TIMEOUT) begin
         @(posedge clk);
         cycles++;
      end
      if (fetch_q.size() < n) abort_run({name, ": timed out waiting for fetches"});
   endtask

   task automatic test_fetch_order;
      restart_core();
      clear_prog();
      repeat (4) emit(NOP);
      emit(enc_addi(5'd9, 5'd0, 12'h055));
      emit(enc_sw(5'd9, 5'd0, 12'h010));
      release_core();
      wait_dbus(1, "fetch_order");
      wait_fetch(8, "fetch_order");
      for (int i = 0; i < 8; i++) check_word("fetch_order", 32'(i * 4), fetch_q[i]);
      check_word("fetch_order_adr", 32'h10, dadr_q[0]);
      check_word("fetch_order_dat", 32'h55, ddat_q[0]);
   endtask

   task automatic test_lui_imm;
      logic [19:0] u;
      logic [11:0] imm [4];
      logic [11:0] off [5];
      logic [31:0] x1;
      logic [31:0] exp [5];
      u = $random(seed);
      for (int i = 0; i < 4; i++) imm[i] = $random(seed);
      for (int i = 0; i < 5; i++) off[i] = 12'(-(($random(seed) & 8'hff) + 1));
      x1 = {u, 12'h000};
      exp[0] = x1;
      exp[1] = x1 + sext12(imm[0]);
      exp[2] = x1 ^ sext12(imm[1]);
      exp[3] = x1 | sext12(imm[2]);
      exp[4] = x1 & sext12(imm[3]);
      restart_core();
      clear_prog();
      emit(enc_addi(5'd5, 5'd0, 12'h200));
      emit(enc_lui(5'd1, u));
      emit(enc_sw(5'd1, 5'd5, off[0]));
      emit(enc_addi(5'd2, 5'd1, imm[0]));
      emit(enc_sw(5'd2, 5'd5, off[1]));
      emit(enc_i(7'b0010011, 5'd3, 3'b100, 5'd1, imm[1]));
      emit(enc_sw(5'd3, 5'd5, off[2]));
      emit(enc_i(7'b0010011, 5'd4, 3'b110, 5'd1, imm[2]));
      emit(enc_sw(5'd4, 5'd5, off[3]));
      emit(enc_i(7'b0010011, 5'd6, 3'b111, 5'd1, imm[3]));
      emit(enc_sw(5'd6, 5'd5, off[4]));
      release_core();
      wait_dbus(5, "lui_imm");
      for (int i = 0; i < 5; i++) begin
         check_word("lui_imm_dat", exp[i], ddat_q[i]);
         check_word("lui_imm_adr", (32'h200 + sext12(off[i])) & ~32'h3, dadr_q[i]);
      end
   endtask

   // Operands built as lui plus addi, with the upper part rounded for the sign
   task automatic load_const(input logic [4:0] rd, input logic [31:0] v);
      logic [31:0] hi;
      hi = v + 32'h800;
      emit(enc_lui(rd, hi[31:12]));
      emit(enc_addi(rd, rd, v[11:0]));
   endtask

   task automatic test_reg_reg(input logic [31:0] a, input logic [31:0] b);
      logic [31:0] exp [5];
      exp[0] = a + b;
      exp[1] = a - b;
      exp[2] = a ^ b;
      exp[3] = a | b;
      exp[4] = a & b;
      restart_core();
      clear_prog();
      load_const(5'd1, a);
      load_const(5'd2, b);
      emit(enc_r(7'h00, 5'd3, 3'b000, 5'd1, 5'd2));
      emit(enc_r(7'h20, 5'd4, 3'b000, 5'd1, 5'd2));
      emit(enc_r(7'h00, 5'd6, 3'b100, 5'd1, 5'd2));
      emit(enc_r(7'h00, 5'd7, 3'b110, 5'd1, 5'd2));
      emit(enc_r(7'h00, 5'd8, 3'b111, 5'd1, 5'd2));
      emit(enc_sw(5'd3, 5'd0, 12'h300));
      emit(enc_sw(5'd4, 5'd0, 12'h304));
      emit(enc_sw(5'd6, 5'd0, 12'h308));
      emit(enc_sw(5'd7, 5'd0, 12'h30c));
      emit(enc_sw(5'd8, 5'd0, 12'h310));
      release_core();
      wait_dbus(5, "reg_reg");
      for (int i = 0; i < 5; i++) begin
         check_word("reg_reg_dat", exp[i], ddat_q[i]);
         check_word("reg_reg_adr", 32'h300 + 32'(i * 4), dadr_q[i]);
      end
   endtask

   task automatic test_load;
      logic [31:0] w;
      w = $random(seed);
      restart_core();
      dmem[32'h180 >> 2] = w;
      clear_prog();
      emit(enc_addi(5'd5, 5'd0, 12'h200));
      emit(enc_i(7'b0000011, 5'd7, 3'b010, 5'd5, 12'hf80));
      emit(enc_sw(5'd7, 5'd5, 12'h040));
      release_core();
      wait_dbus(2, "load");
      check_word("load_adr", 32'h180, dadr_q[0]);
      check_word("load_we", 32'h0, 32'(dwe_q[0]));
      check_word("load_store_adr", 32'h240, dadr_q[1]);
      check_word("load_store_we", 32'h1, 32'(dwe_q[1]));
      check_word("load_store_dat", w, ddat_q[1]);
   endtask

   task automatic test_x0;
      restart_core();
      clear_prog();
      emit(enc_addi(5'd0, 5'd0, 12'h7ff));
      emit(enc_lui(5'd0, 20'habcde));
      emit(enc_sw(5'd0, 5'd0, 12'h100));
      release_core();
      wait_dbus(1, "x0");
      check_word("x0_adr", 32'h100, dadr_q[0]);
      check_word("x0_dat", 32'h0, ddat_q[0]);
   endtask

   initial begin
      seed       = 37;
      err_count  = 0;
      hold_reset = 1'b1;
      ibus_rdt   = '0;
      ibus_ack   = 1'b0;
      dbus_rdt   = '0;
      dbus_ack   = 1'b0;
      iwait      = -1;
      dwait      = -1;
      for (int i = 0; i < 256; i++) dmem[i] = (32'(i) * 32'h9e37_79b1) ^ 32'h5a5a_0000;
      clear_prog();

      test_fetch_order();
      test_lui_imm();
      test_reg_reg($random(seed), $random(seed));
      // Small minus large wraps around
      test_reg_reg($random(seed) & 32'hff, $random(seed) | 32'h8000_0000);
      test_load();
      test_x0();

      $display("Errors: %0d", err_count);
      if (err_count == 0) begin
         $display("test passed");
      end else begin
         $display("test failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: verif/tb_clock.sv
`timescale 1ns/1ns
`default_nettype none

module tb_clock (
   output logic clk,
   output logic o_reset
);

   initial begin
      clk     = 1'b0;
      o_reset = 1'b1;
      repeat (8) @(posedge clk);
      #1 o_reset = 1'b0;
   end

   always #5 clk = ~clk;

endmodule

`default_nettype wire
